// File: flist.f
logic/icache_pkg.sv
logic/way_access_if.sv
logic/icache_ram.sv
logic/icache_way.sv
logic/icache_hit_select.sv
logic/icache_ctrl.sv
logic/icache_top.sv
sim/icache_props.sv
sim/icache_tb.sv

// File: Bender.yml
package:
  name: icache

sources:
  - files:
      - logic/icache_pkg.sv
      - logic/way_access_if.sv
      - logic/icache_ram.sv
      - logic/icache_way.sv
      - logic/icache_hit_select.sv
      - logic/icache_ctrl.sv
      - logic/icache_top.sv
  - target: simulation
    files:
      - sim/icache_props.sv
      - sim/icache_tb.sv

// File: sim/icache_tb.sv
// testbench for the instruction cache
// table of fetches with expected refills, refill and uncached memory
// models, response and latency checks, flush during a refill
`timescale 1ns/100ps

module icache_tb;
    import icache_pkg::*;

    localparam int unsigned LINE_WORDS  = 4;
    localparam int unsigned LINE_BYTES  = LINE_WORDS * BYTES_PER_WORD;
    localparam word_t       MEM_PATTERN = 32'h5a5a_0000;
    localparam word_t       IO_PATTERN  = 32'hc3c3_0000;
    localparam addr_t       FLUSH_ADDR  = 32'h0000_2a40;
    localparam int          NUM_STEPS   = 19;
    localparam int          TIMEOUT     = NUM_STEPS * 40 + 200;

    typedef struct packed {
        addr_t      addr;
        logic       cacheable;
        logic [3:0] stall_cycles;   // cycles the response is held
        logic       expect_refill;
    } step_t;

    // tree PLRU victims in set 5 take the fills in ways 0,2,1,3
    localparam step_t STEPS [NUM_STEPS] = '{
        '{32'h0000_1238, 1'b1, 4'd0, 1'b1},  // cold miss
        '{32'h0000_1230, 1'b1, 4'd0, 1'b0},
        '{32'h0000_1234, 1'b1, 4'd0, 1'b0},
        '{32'h0000_123c, 1'b1, 4'd3, 1'b0},  // hit, then stalled
        '{32'h0000_1238, 1'b1, 4'd0, 1'b0},
        '{32'h0001_0050, 1'b1, 4'd0, 1'b1},  // A to way 0
        '{32'h0002_0054, 1'b1, 4'd0, 1'b1},  // B to way 2
        '{32'h0003_0058, 1'b1, 4'd0, 1'b1},  // C to way 1
        '{32'h0004_005c, 1'b1, 4'd0, 1'b1},  // D to way 3
        '{32'h0005_0050, 1'b1, 4'd0, 1'b1},  // E evicts A
        '{32'h0001_0054, 1'b1, 4'd0, 1'b1},  // A back, evicts B
        '{32'h0003_0050, 1'b1, 4'd0, 1'b0},  // C still in way 1
        '{32'h0002_0050, 1'b1, 4'd0, 1'b1},  // B evicts D
        '{32'h0004_0050, 1'b1, 4'd0, 1'b1},  // D evicts E
        '{32'h0003_005c, 1'b1, 4'd0, 1'b0},
        '{32'h8000_0104, 1'b0, 4'd2, 1'b0},  // uncached and stalled in IO_DONE
        '{32'h8000_0104, 1'b0, 4'd0, 1'b0},
        '{32'h0000_1234, 1'b0, 4'd0, 1'b0},  // uncached fetch of a cached line
        '{32'h0000_1234, 1'b1, 4'd0, 1'b0}
    };

    logic                   clk;
    logic                   reset;
    logic                   fetch_valid;
    addr_t                  fetch_addr;
    logic                   fetch_cacheable;
    logic                   stall;
    logic                   flush;
    logic                   busy;
    logic                   resp_valid;
    word_t                  resp_data;
    logic                   mem_rd_req;
    addr_t                  mem_rd_addr;
    logic                   mem_rd_rdy;
    logic                   mem_ret_valid;
    word_t [LINE_WORDS-1:0] mem_ret_line;
    logic                   io_rd_req;
    addr_t                  io_rd_addr;
    logic                   io_rd_rdy;
    logic                   io_ret_valid;
    word_t                  io_ret_data;

    int    mem_reqs    = 0;   // line requests served
    int    io_reqs     = 0;   // uncached requests served
    int    cycle_count = 0;
    addr_t last_line_addr;
    addr_t last_io_addr;

    icache_top dut (.*);

    always #2 clk = ~clk;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            stop_with_failure($sformatf("ERR %0t %s got %h expected %h",
                                        $time, name, got, exp));
        end
    endtask

    // random wait for rdy on a line request, then for the returned line
    task automatic serve_refill();
        addr_t                  line_addr;
        word_t [LINE_WORDS-1:0] line;
        line_addr      = mem_rd_addr;
        last_line_addr = line_addr;
        mem_reqs++;
        for (int w = 0; w < LINE_WORDS; w++) begin
            line[w] = (line_addr + addr_t'(w * BYTES_PER_WORD)) ^ MEM_PATTERN;
        end
        repeat (1 + $urandom % 6) @(posedge clk);
        mem_rd_rdy <= 1'b1;
        @(posedge clk);
        mem_rd_rdy <= 1'b0;
        repeat (1 + $urandom % 6) @(posedge clk);
        mem_ret_valid <= 1'b1;
        mem_ret_line  <= line;
        @(posedge clk);
        mem_ret_valid <= 1'b0;
    endtask

    task automatic serve_uncached();
        addr_t addr;
        addr         = io_rd_addr;
        last_io_addr = addr;
        io_reqs++;
        repeat (1 + $urandom % 6) @(posedge clk);
        io_rd_rdy <= 1'b1;
        @(posedge clk);
        io_rd_rdy <= 1'b0;
        repeat (1 + $urandom % 6) @(posedge clk);
        io_ret_valid <= 1'b1;
        io_ret_data  <= addr ^ IO_PATTERN;
        @(posedge clk);
        io_ret_valid <= 1'b0;
    endtask

    // presents a fetch, waits for acceptance and then for the response
    task automatic fetch_and_check(input step_t s);
        int    mem_before;
        int    io_before;
        int    wait_cnt;
        word_t exp;
        word_t held;
        mem_before = mem_reqs;
        io_before  = io_reqs;
        exp        = s.addr ^ (s.cacheable ? MEM_PATTERN : IO_PATTERN);
        @(posedge clk);
        fetch_valid     <= 1'b1;
        fetch_addr      <= s.addr;
        fetch_cacheable <= s.cacheable;
        do @(negedge clk); while (busy);
        @(posedge clk);                          // accepted at this edge
        fetch_valid <= 1'b0;
        stall       <= (s.stall_cycles != 0);
        wait_cnt = 0;
        do begin
            @(negedge clk);
            wait_cnt++;
        end while (!resp_valid);
        expect_equal("resp_data", resp_data, exp);
        expect_equal("refill count", mem_reqs - mem_before, int'(s.expect_refill));
        expect_equal("uncached count", io_reqs - io_before, int'(!s.cacheable));
        if (s.expect_refill) begin
            expect_equal("mem_rd_addr", last_line_addr, s.addr & ~addr_t'(LINE_BYTES - 1));
        end
        if (!s.cacheable) begin
            expect_equal("io_rd_addr", last_io_addr, s.addr);
        end
        if (s.cacheable && !s.expect_refill) begin
            expect_equal("hit latency", wait_cnt, 1);
        end
        if (s.stall_cycles != 0) begin
            held = resp_data;
            repeat (s.stall_cycles) begin
                @(negedge clk);
                assert (resp_valid) else stop_with_failure("response dropped during stall");
                expect_equal("resp_data", resp_data, held);
            end
            @(posedge clk);
            stall <= 1'b0;
        end
    endtask

    // flush while the line is on its way and expect it written anyway
    task automatic flush_during_refill();
        int    mem_before;
        step_t s;
        mem_before = mem_reqs;
        @(posedge clk);
        fetch_valid     <= 1'b1;
        fetch_addr      <= FLUSH_ADDR;
        fetch_cacheable <= 1'b1;
        do @(negedge clk); while (busy);
        @(posedge clk);
        fetch_valid <= 1'b0;
        do @(negedge clk); while (!mem_rd_req);
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        do begin
            @(negedge clk);
            assert (!resp_valid) else stop_with_failure("response given for a flushed fetch");
        end while (busy);
        repeat (3) begin
            @(negedge clk);
            assert (!resp_valid) else stop_with_failure("response given for a flushed fetch");
        end
        expect_equal("refill count", mem_reqs - mem_before, 1);
        s = '{FLUSH_ADDR + 32'h8, 1'b1, 4'd0, 1'b0};
        fetch_and_check(s);
    endtask

    // refill and uncached memory models serving one request at a time
    initial begin
        mem_rd_rdy    = 1'b0;
        mem_ret_valid = 1'b0;
        mem_ret_line  = '0;
        io_rd_rdy     = 1'b0;
        io_ret_valid  = 1'b0;
        io_ret_data   = '0;
        void'($urandom(32'hecd8992e));
        forever begin
            @(negedge clk);
            if (mem_rd_req) begin
                serve_refill();
            end else if (io_rd_req) begin
                serve_uncached();
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            stop_with_failure($sformatf("timeout, run not finished after %0d cycles", TIMEOUT));
        end else if (dut.u_props.violations != 0) begin
            stop_with_failure("bound port checks reported a violation");
        end
    end

    initial begin
        clk             = 1'b0;
        reset           = 1'b1;
        fetch_valid     = 1'b0;
        fetch_addr      = '0;
        fetch_cacheable = 1'b0;
        stall           = 1'b0;
        flush           = 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (!busy && !resp_valid && !mem_rd_req && !io_rd_req)
        else stop_with_failure("cache outputs not idle after reset");

        for (int i = 0; i < NUM_STEPS; i++) begin
            fetch_and_check(STEPS[i]);
        end
        flush_during_refill();

        repeat (2) @(posedge clk);
        if (dut.u_props.violations == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            stop_with_failure("bound port checks reported violations");
        end
    end

endmodule

// File: sim/icache_props.sv
// port rules of the instruction cache
// bound into the cache top level; checks the memory port exclusivity,
// response against busy, and a response held under stall
`timescale 1ns/100ps

module icache_props (
    input logic              clk,
    input logic              reset,
    input logic              stall,
    input logic              flush,
    input logic              busy,
    input logic              resp_valid,
    input icache_pkg::word_t resp_data,
    input logic              mem_rd_req,
    input logic              io_rd_req
);

    int violations = 0;   // polled by the testbench every cycle

    ports_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(mem_rd_req && io_rd_req))
    else begin
        $error("refill and uncached requests raised together");
        violations++;
    end

    resp_not_busy: assert property (@(posedge clk) disable iff (reset)
        !(resp_valid && busy))
    else begin
        $error("resp_valid high while busy");
        violations++;
    end

    // a stalled response stays in place for the next cycle
    resp_held: assert property (@(posedge clk) disable iff (reset)
        (stall && resp_valid && !flush) |=> (resp_valid && $stable(resp_data)))
    else begin
        $error("response changed while stalled");
        violations++;
    end

endmodule

bind icache_top icache_props u_props (
    .clk        (clk),
    .reset      (reset),
    .stall      (stall),
    .flush      (flush),
    .busy       (busy),
    .resp_valid (resp_valid),
    .resp_data  (resp_data),
    .mem_rd_req (mem_rd_req),
    .io_rd_req  (io_rd_req)
);

// File: logic/icache_top.sv
// set-associative instruction cache
// controller, a row of identical ways and the hit selector with PLRU;
// plain request and return ports to the CPU, refill memory and uncached bus
`timescale 1ns/100ps

module icache_top #(
    parameter int unsigned LINE_WORDS = 4,
    parameter int unsigned ASSOC_NUM  = 4,
    parameter int unsigned SET_NUM    = 64
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 fetch_valid,
    input  icache_pkg::addr_t                    fetch_addr,
    input  logic                                 fetch_cacheable,
    input  logic                                 stall,
    input  logic                                 flush,
    output logic                                 busy,
    output logic                                 resp_valid,
    output icache_pkg::word_t                    resp_data,
    output logic                                 mem_rd_req,
    output icache_pkg::addr_t                    mem_rd_addr,
    input  logic                                 mem_rd_rdy,
    input  logic                                 mem_ret_valid,
    input  icache_pkg::word_t [LINE_WORDS-1:0]   mem_ret_line,
    output logic                                 io_rd_req,
    output icache_pkg::addr_t                    io_rd_addr,
    input  logic                                 io_rd_rdy,
    input  logic                                 io_ret_valid,
    input  icache_pkg::word_t                    io_ret_data
);
    import icache_pkg::*;

    localparam int unsigned INDEX_WIDTH  = $clog2(SET_NUM);
    localparam int unsigned OFFSET_WIDTH = $clog2(LINE_WORDS * BYTES_PER_WORD);
    localparam int unsigned TAG_WIDTH    = 32 - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int unsigned WAY_WIDTH    = $clog2(ASSOC_NUM);

    logic [ASSOC_NUM-1:0]        way_hit;
    word_t [ASSOC_NUM-1:0]       way_word;
    logic                        any_hit;
    logic [WAY_WIDTH-1:0]        victim_way;
    word_t                       sel_word;
    logic [INDEX_WIDTH-1:0]      set_index;
    logic                        access_valid;

    way_access_if #(
        .INDEX_WIDTH (INDEX_WIDTH),
        .TAG_WIDTH   (TAG_WIDTH),
        .LINE_WORDS  (LINE_WORDS),
        .WAY_WIDTH   (WAY_WIDTH)
    ) wa ();

    icache_ctrl #(
        .LINE_WORDS (LINE_WORDS),
        .ASSOC_NUM  (ASSOC_NUM),
        .SET_NUM    (SET_NUM)
    ) u_ctrl (
        .clk, .reset,
        .fetch_valid, .fetch_addr, .fetch_cacheable, .stall, .flush,
        .busy, .resp_valid, .resp_data,
        .mem_rd_req, .mem_rd_addr, .mem_rd_rdy, .mem_ret_valid, .mem_ret_line,
        .io_rd_req, .io_rd_addr, .io_rd_rdy, .io_ret_valid, .io_ret_data,
        .wa           (wa),
        .any_hit      (any_hit),
        .victim_way   (victim_way),
        .sel_word     (sel_word),
        .set_index    (set_index),
        .access_valid (access_valid)
    );

    for (genvar i = 0; i < ASSOC_NUM; i++) begin : g_way
        icache_way #(
            .WAY_ID     (i),
            .SET_NUM    (SET_NUM),
            .LINE_WORDS (LINE_WORDS)
        ) u_way (
            .clk   (clk),
            .reset (reset),
            .wa    (wa),
            .hit   (way_hit[i]),
            .word  (way_word[i])
        );
    end

    icache_hit_select #(
        .ASSOC_NUM (ASSOC_NUM),
        .SET_NUM   (SET_NUM)
    ) u_hit_select (
        .clk          (clk),
        .reset        (reset),
        .hit          (way_hit),
        .word         (way_word),
        .set_index    (set_index),
        .access_valid (access_valid),
        .refill_done  (wa.refill_en),
        .any_hit      (any_hit),
        .victim_way   (victim_way),
        .sel_word     (sel_word)
    );

endmodule

// File: logic/icache_ctrl.sv
// instruction cache controller
// request buffer and fetch FSM; drives the refill and uncached ports,
// the way lookups, busy and the response to the CPU
`timescale 1ns/100ps

module icache_ctrl #(
    parameter int unsigned LINE_WORDS = 4,
    parameter int unsigned ASSOC_NUM  = 4,
    parameter int unsigned SET_NUM    = 64
) (
    input  logic                                 clk,
    input  logic                                 reset,
    // CPU side
    input  logic                                 fetch_valid,
    input  icache_pkg::addr_t                    fetch_addr,
    input  logic                                 fetch_cacheable,
    input  logic                                 stall,
    input  logic                                 flush,
    output logic                                 busy,
    output logic                                 resp_valid,
    output icache_pkg::word_t                    resp_data,
    // refill port
    output logic                                 mem_rd_req,
    output icache_pkg::addr_t                    mem_rd_addr,
    input  logic                                 mem_rd_rdy,
    input  logic                                 mem_ret_valid,
    input  icache_pkg::word_t [LINE_WORDS-1:0]   mem_ret_line,
    // uncached port
    output logic                                 io_rd_req,
    output icache_pkg::addr_t                    io_rd_addr,
    input  logic                                 io_rd_rdy,
    input  logic                                 io_ret_valid,
    input  icache_pkg::word_t                    io_ret_data,
    // ways and selector
    way_access_if.ctrl                           wa,
    input  logic                                 any_hit,
    input  logic [$clog2(ASSOC_NUM)-1:0]         victim_way,
    input  icache_pkg::word_t                    sel_word,
    output logic [$clog2(SET_NUM)-1:0]           set_index,
    output logic                                 access_valid
);
    import icache_pkg::*;

    localparam int unsigned INDEX_WIDTH  = $clog2(SET_NUM);
    localparam int unsigned OFFSET_WIDTH = $clog2(LINE_WORDS * BYTES_PER_WORD);
    localparam int unsigned TAG_WIDTH    = 32 - INDEX_WIDTH - OFFSET_WIDTH;

    fetch_state_t state, state_next;

    // request buffer
    logic                    req_valid;
    logic [TAG_WIDTH-1:0]    req_tag;
    logic [INDEX_WIDTH-1:0]  req_index;
    logic [OFFSET_WIDTH-1:0] req_offset;
    logic                    req_cacheable;

    word_t io_word;
    logic  req_en;
    logic  accept;
    logic  rd_en;
    logic  wr_en;
    logic  in_flight;

    assign req_en    = ~busy & ~stall;
    assign accept    = fetch_valid & req_en;
    assign in_flight = (state != LOOKUP) && (state != IO_DONE);

    // a cached miss or an uncached request keeps the CPU waiting
    assign busy = in_flight || (state == LOOKUP && req_valid && (!req_cacheable || !any_hit));

    assign access_valid = (state == LOOKUP) && req_valid && req_cacheable && any_hit;
    assign resp_valid   = access_valid || (state == IO_DONE && req_valid);
    assign resp_data    = (state == IO_DONE) ? io_word : sel_word;
    assign set_index    = req_index;

    assign mem_rd_req  = (state == MISS_REQ);
    assign mem_rd_addr = {req_tag, req_index, {OFFSET_WIDTH{1'b0}}};  // line aligned
    assign io_rd_req   = (state == IO_REQ);
    assign io_rd_addr  = {req_tag, req_index, req_offset};

    assign rd_en = accept || (state == REFILL_DONE);
    assign wr_en = (state == REFILL) && mem_ret_valid;

    // refill and its reread use the buffered set, otherwise the incoming one
    assign wa.lookup_index  = (state == REFILL || state == REFILL_DONE) ? req_index
                            : fetch_addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign wa.lookup_tag    = req_tag;
    assign wa.lookup_offset = req_offset[OFFSET_WIDTH-1:2];
    assign wa.lookup_en     = rd_en | wr_en;
    assign wa.compare_en    = rd_en;
    assign wa.refill_en     = wr_en;
    assign wa.refill_line   = mem_ret_line;
    assign wa.refill_way    = victim_way;

    // flush drops the request, a refill already under way still finishes
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            req_valid <= 1'b0;
        end else if (req_en) begin
            req_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_en) begin
            req_tag       <= fetch_addr[31 -: TAG_WIDTH];
            req_index     <= fetch_addr[OFFSET_WIDTH +: INDEX_WIDTH];
            req_offset    <= fetch_addr[OFFSET_WIDTH-1:0];
            req_cacheable <= fetch_cacheable;
        end
    end

    always_ff @(posedge clk) begin
        if (state == IO_WAIT && io_ret_valid) begin
            io_word <= io_ret_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= LOOKUP;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        unique case (state)
            LOOKUP: begin
                if (req_valid && !req_cacheable) begin
                    state_next = IO_REQ;
                end else if (req_valid && !any_hit) begin
                    state_next = MISS_REQ;
                end
            end
            MISS_REQ:    if (mem_rd_rdy) state_next = REFILL;
            REFILL:      if (mem_ret_valid) state_next = REFILL_DONE;
            REFILL_DONE: state_next = LOOKUP;   // tags reread, compare next cycle
            IO_REQ:      if (io_rd_rdy) state_next = IO_WAIT;
            IO_WAIT:     if (io_ret_valid) state_next = IO_DONE;
            IO_DONE:     if (!stall) state_next = LOOKUP;
            default:     state_next = LOOKUP;
        endcase
    end

endmodule

// File: logic/icache_hit_select.sv
// hit selection and replacement
// muxes the word of the hitting way and keeps one tree PLRU per set;
// a hit or a refill turns the tree away from the way just used
`timescale 1ns/100ps

module icache_hit_select #(
    parameter int unsigned ASSOC_NUM = 4,
    parameter int unsigned SET_NUM   = 64
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [ASSOC_NUM-1:0]                hit,
    input  icache_pkg::word_t [ASSOC_NUM-1:0]   word,
    input  logic [$clog2(SET_NUM)-1:0]          set_index,
    input  logic                                access_valid,
    input  logic                                refill_done,
    output logic                                any_hit,
    output logic [$clog2(ASSOC_NUM)-1:0]        victim_way,
    output icache_pkg::word_t                   sel_word
);
    import icache_pkg::*;

    localparam int unsigned WAY_WIDTH = $clog2(ASSOC_NUM);

    // node n has children 2n and 2n+1, ways are the leaves
    typedef logic [ASSOC_NUM-1:1] tree_t;
    typedef logic [WAY_WIDTH-1:0] way_t;

    tree_t plru [SET_NUM];
    way_t  hit_way;

    // follow the bits from the root down to the leaf to replace
    function automatic way_t pick_victim(input tree_t t);
        int unsigned node;
        node = 1;
        for (int l = 0; l < WAY_WIDTH; l++) begin
            node = 2 * node + int'(t[node]);
        end
        return way_t'(node - ASSOC_NUM);
    endfunction

    // point every node on the path of w to the other subtree
    function automatic tree_t touch(input tree_t t, input way_t w);
        tree_t       r;
        int unsigned node;
        r    = t;
        node = 1;
        for (int l = WAY_WIDTH - 1; l >= 0; l--) begin
            r[node] = ~w[l];
            node    = 2 * node + int'(w[l]);
        end
        return r;
    endfunction

    always_comb begin
        hit_way = '0;
        for (int i = 0; i < ASSOC_NUM; i++) begin
            if (hit[i]) begin
                hit_way = way_t'(i);
            end
        end
    end

    assign any_hit    = |hit;
    assign sel_word   = word[hit_way];
    assign victim_way = pick_victim(plru[set_index]);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < SET_NUM; s++) begin
                plru[s] <= '0;
            end
        end else if (access_valid) begin
            plru[set_index] <= touch(plru[set_index], hit_way);
        end else if (refill_done) begin
            plru[set_index] <= touch(plru[set_index], victim_way);  // new line counts as used
        end
    end

endmodule

// File: logic/icache_way.sv
// one way of the instruction cache
// tag and line RAMs plus valid bits; compares the read tag with the
// buffered request tag and picks the requested word from the line
`timescale 1ns/100ps

module icache_way #(
    parameter int          WAY_ID     = 0,
    parameter int unsigned SET_NUM    = 64,
    parameter int unsigned LINE_WORDS = 4
) (
    input  logic               clk,
    input  logic               reset,
    way_access_if.way          wa,
    output logic               hit,
    output icache_pkg::word_t  word
);
    import icache_pkg::*;

    localparam int unsigned INDEX_WIDTH  = $clog2(SET_NUM);
    localparam int unsigned OFFSET_WIDTH = $clog2(LINE_WORDS * BYTES_PER_WORD);
    localparam int unsigned TAG_WIDTH    = 32 - INDEX_WIDTH - OFFSET_WIDTH;

    typedef logic [TAG_WIDTH-1:0]  tag_t;
    typedef word_t [LINE_WORDS-1:0] line_t;

    logic               we;
    logic [SET_NUM-1:0] valid_bits;
    logic               valid_q;     // valid of the set read with the tags
    tag_t               tag_rd;
    line_t              line_rd;

    assign we = wa.refill_en && (int'(wa.refill_way) == WAY_ID);

    icache_ram #(.DEPTH(SET_NUM), .entry_t(tag_t)) u_tag_ram (
        .clk   (clk),
        .en    (wa.lookup_en),
        .we    (we),
        .addr  (wa.lookup_index),
        .wdata (wa.lookup_tag),
        .rdata (tag_rd)
    );

    icache_ram #(.DEPTH(SET_NUM), .entry_t(line_t)) u_line_ram (
        .clk   (clk),
        .en    (wa.lookup_en),
        .we    (we),
        .addr  (wa.lookup_index),
        .wdata (wa.refill_line),
        .rdata (line_rd)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (we) begin
            valid_bits[wa.lookup_index] <= 1'b1;  // line stays valid until reset
        end
    end

    // held together with the RAM outputs while no read is enabled
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (wa.compare_en) begin
            valid_q <= valid_bits[wa.lookup_index];
        end
    end

    assign hit  = valid_q && (tag_rd == wa.lookup_tag);
    assign word = line_rd[wa.lookup_offset];

endmodule

// File: logic/icache_ram.sv
// single-port synchronous RAM
// read-first, one cycle read latency, entry type set per instance
`timescale 1ns/100ps

module icache_ram #(
    parameter int unsigned DEPTH = 64,
    parameter type         entry_t = logic
) (
    input  logic                     clk,
    input  logic                     en,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  entry_t                   wdata,
    output entry_t                   rdata
);

    entry_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr];  // old contents on a write
        end
    end

endmodule

// File: logic/way_access_if.sv
// controller to way bundle
// lookup address, compare strobes and refill write data shared by all ways
`timescale 1ns/100ps

interface way_access_if #(
    parameter int unsigned INDEX_WIDTH = 6,
    parameter int unsigned TAG_WIDTH   = 22,
    parameter int unsigned LINE_WORDS  = 4,
    parameter int unsigned WAY_WIDTH   = 2
);
    import icache_pkg::*;

    logic [INDEX_WIDTH-1:0]        lookup_index;   // set read or written this cycle
    logic [TAG_WIDTH-1:0]          lookup_tag;     // tag of the buffered request
    logic [$clog2(LINE_WORDS)-1:0] lookup_offset;  // word within the line
    logic                          lookup_en;      // RAM enable, read or write
    logic                          compare_en;     // loads the compare registers
    logic                          refill_en;
    word_t [LINE_WORDS-1:0]        refill_line;
    logic [WAY_WIDTH-1:0]          refill_way;     // victim taking the line

    modport ctrl (
        output lookup_index, lookup_tag, lookup_offset, lookup_en, compare_en,
        output refill_en, refill_line, refill_way
    );

    modport way (
        input lookup_index, lookup_tag, lookup_offset, lookup_en, compare_en,
        input refill_en, refill_line, refill_way
    );

endinterface

// File: logic/icache_pkg.sv
// instruction cache shared definitions
// address and word types, fetch FSM encoding and word size
package icache_pkg;

    typedef logic [31:0] addr_t;   // byte address of a fetch
    typedef logic [31:0] word_t;   // one instruction word

    localparam int unsigned BYTES_PER_WORD = 4;

    // fetch FSM of the cache controller
    typedef enum logic [2:0] {
        LOOKUP,        // tag compare of the buffered request
        MISS_REQ,      // line request held on the refill port
        REFILL,        // waiting for the returned line
        REFILL_DONE,   // reread of the refilled set
        IO_REQ,        // single word request on the uncached port
        IO_WAIT,       // waiting for the uncached word
        IO_DONE        // uncached word presented to the CPU
    } fetch_state_t;

endpackage
